// File: list.f
+incdir+include
rtl/objram_pkg.sv
rtl/objram_cfg_regs.sv
rtl/objram_cpu_write.sv
rtl/objram_dual_ram.sv
rtl/objram_bank_store.sv
rtl/objram_obj_read.sv
rtl/objram_top.sv
testbench/objram_tb.sv

// File: rtl/objram_bank_store.sv
/* Double-banked object table */
`timescale 1ns/1ns
`default_nettype none

module objram_bank_store #(
    parameter int AW = 13
) (
    input  wire logic                clk_cpu,
    input  wire objram_pkg::ram_wr_t ram_wr,
    input  wire logic                wr_en,
    input  wire logic                obank,
    input  wire logic [AW-4:0]       rd_addr,
    output objram_pkg::obj_entry_t   rd_entry
);

    logic [1:0]    we_x;
    logic [1:0]    we_y;
    logic [1:0]    we_code;
    logic [1:0]    we_attr;
    logic [AW-3:0] disp_addr;
    logic [15:0]   q_x;
    logic [15:0]   q_y;
    logic [15:0]   q_code;
    logic [15:0]   q_attr;

    // Steer byte enables to the RAM of the addressed word
    always_comb begin
        we_x    = 2'b00;
        we_y    = 2'b00;
        we_code = 2'b00;
        we_attr = 2'b00;
        if (wr_en) begin
            case (ram_wr.field)
                objram_pkg::FIELD_X:    we_x    = ram_wr.be;
                objram_pkg::FIELD_Y:    we_y    = ram_wr.be;
                objram_pkg::FIELD_CODE: we_code = ram_wr.be;
                default:                we_attr = ram_wr.be;
            endcase
        end
    end

    // Engine always reads the displayed bank
    assign disp_addr = {~obank, rd_addr};

    objram_dual_ram #(.AW(AW)) u_x (
        .clk_cpu ( clk_cpu          ),
        .we      ( we_x             ),
        .wr_addr ( ram_wr.bank_addr ),
        .wr_data ( ram_wr.data      ),
        .rd_addr ( disp_addr        ),
        .rd_data ( q_x              )
    );

    objram_dual_ram #(.AW(AW)) u_y (
        .clk_cpu ( clk_cpu          ),
        .we      ( we_y             ),
        .wr_addr ( ram_wr.bank_addr ),
        .wr_data ( ram_wr.data      ),
        .rd_addr ( disp_addr        ),
        .rd_data ( q_y              )
    );

    objram_dual_ram #(.AW(AW)) u_code (
        .clk_cpu ( clk_cpu          ),
        .we      ( we_code          ),
        .wr_addr ( ram_wr.bank_addr ),
        .wr_data ( ram_wr.data      ),
        .rd_addr ( disp_addr        ),
        .rd_data ( q_code           )
    );

    objram_dual_ram #(.AW(AW)) u_attr (
        .clk_cpu ( clk_cpu          ),
        .we      ( we_attr          ),
        .wr_addr ( ram_wr.bank_addr ),
        .wr_data ( ram_wr.data      ),
        .rd_addr ( disp_addr        ),
        .rd_data ( q_attr           )
    );

    // All four words of the entry side by side
    assign rd_entry = '{x: q_x, y: q_y, code: q_code, attr: q_attr};

endmodule

`default_nettype wire

// File: rtl/objram_cfg_regs.sv
/* Object offset registers */
`timescale 1ns/1ns
`default_nettype none

module objram_cfg_regs (
    input  wire logic                   clk_cpu,
    input  wire logic                   rst,
    input  wire objram_pkg::cfg_req_t   cfg_req,
    output objram_pkg::obj_offset_t     offsets
);

    logic       wr_x;
    logic       wr_y;
    logic [9:0] merged_x;
    logic [8:0] merged_y;
    logic [9:0] next_x;
    logic [8:0] next_y;

    // Register decode
    assign wr_x = cfg_req.cs && (cfg_req.addr == objram_pkg::XOFF_REG);
    assign wr_y = cfg_req.cs && (cfg_req.addr == objram_pkg::YOFF_REG);

    // Lane merge, disabled lanes keep the current value
    // Upper lane only holds bits 9:8 of X
    assign merged_x = {
        cfg_req.dsn[1] ? offsets.off_x[9:8] : cfg_req.data[9:8],
        cfg_req.dsn[0] ? offsets.off_x[7:0] : cfg_req.data[7:0]
    };

    // Only bit 8 of Y lives in the upper lane
    assign merged_y = {
        cfg_req.dsn[1] ? offsets.off_y[8]   : cfg_req.data[8],
        cfg_req.dsn[0] ? offsets.off_y[7:0] : cfg_req.data[7:0]
    };

    // Bias removal, wraps at register width
    assign next_x = merged_x - objram_pkg::X_BIAS;
    assign next_y = merged_y - objram_pkg::Y_BIAS;

    always_ff @(posedge clk_cpu or posedge rst) begin
        if (rst) begin
            offsets <= '0;
        end else begin
            if (wr_x) begin
                offsets.off_x <= next_x;
            end
            if (wr_y) begin
                offsets.off_y <= next_y;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/objram_cpu_write.sv
/* CPU write path */
`timescale 1ns/1ns
`default_nettype none

module objram_cpu_write #(
    parameter int AW = 13
) (
    input  wire logic                    clk_cpu,
    input  wire logic                    rst,
    input  wire objram_pkg::cpu_req_t    cpu_req,
    input  wire logic                    obank,
    input  wire objram_pkg::obj_offset_t offsets,
    output logic                         ok,
    output objram_pkg::ram_wr_t          ram_wr,
    output logic                         wr_en
);

    objram_pkg::obj_field_e field;
    logic [AW-3:0]          bank_addr;
    logic [15:0]            data_adj;

    // Word select within the entry
    assign field = objram_pkg::obj_field_e'(cpu_req.addr[2:1]);

    // Top address bit picks the visible or hidden bank
    // obank flips which physical bank that is
    assign bank_addr = {obank ^ cpu_req.addr[13], cpu_req.addr[AW-1:3]};

    // Position words get the global offset removed
    always_comb begin
        data_adj = cpu_req.data;
        case (field)
            objram_pkg::FIELD_X: begin
                data_adj[9:0] = cpu_req.data[9:0] - offsets.off_x;
            end
            objram_pkg::FIELD_Y: begin
                data_adj[8:0] = cpu_req.data[8:0] - offsets.off_y;
            end
            default: begin
                data_adj = cpu_req.data;
            end
        endcase
    end

    // Acknowledge, also the RAM write strobe
    always_ff @(posedge clk_cpu or posedge rst) begin
        if (rst) begin
            ok <= 1'b0;
        end else begin
            ok <= cpu_req.cs;
        end
    end

    assign wr_en = ok;

    // Write payload held for the RAM cycle
    always_ff @(posedge clk_cpu) begin
        if (cpu_req.cs) begin
            ram_wr.field     <= field;
            ram_wr.bank_addr <= bank_addr;
            ram_wr.be        <= ~cpu_req.dsn;
            ram_wr.data      <= data_adj;
        end
    end

    // Every RAM write carries a fully known payload
    write_payload_known: assert property (
        @(posedge clk_cpu) disable iff (rst) wr_en |-> !$isunknown(ram_wr)
    );

endmodule

`default_nettype wire

// File: rtl/objram_dual_ram.sv
/* Byte-lane field RAM */
`timescale 1ns/1ns
`default_nettype none

module objram_dual_ram #(
    parameter int AW = 13
) (
    input  wire logic          clk_cpu,
    input  wire logic [1:0]    we,
    input  wire logic [AW-3:0] wr_addr,
    input  wire logic [15:0]   wr_data,
    input  wire logic [AW-3:0] rd_addr,
    output logic      [15:0]   rd_data
);

    // Both banks, bank bit is the address MSB
    localparam int DEPTH = 2 ** (AW - 2);

    logic [15:0] mem [DEPTH];

    // Write port, each lane enabled on its own
    always_ff @(posedge clk_cpu) begin
        if (we[0]) begin
            mem[wr_addr][7:0] <= wr_data[7:0];
        end
        if (we[1]) begin
            mem[wr_addr][15:8] <= wr_data[15:8];
        end
    end

    // Registered read, old data on a same-address collision
    always_ff @(posedge clk_cpu) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: rtl/objram_obj_read.sv
/* Object engine read port */
`timescale 1ns/1ns
`default_nettype none

module objram_obj_read #(
    parameter int AW = 13
) (
    input  wire logic                   clk_cpu,
    input  wire logic                   rst,
    input  wire logic                   obj_rd,
    input  wire logic [AW-4:0]          obj_idx,
    output logic      [AW-4:0]          rd_addr,
    input  wire objram_pkg::obj_entry_t rd_entry,
    output logic                        obj_valid,
    output objram_pkg::obj_entry_t      obj_entry
);

    // Request seen by the RAM this cycle, data due next edge
    logic rd_pend;

    // Index goes straight to the RAM read port
    assign rd_addr = obj_idx;

    // Two-stage valid, RAM read then output register
    always_ff @(posedge clk_cpu or posedge rst) begin
        if (rst) begin
            rd_pend   <= 1'b0;
            obj_valid <= 1'b0;
        end else begin
            rd_pend   <= obj_rd;
            obj_valid <= rd_pend;
        end
    end

    // Output register, loaded only when RAM data is for a request
    always_ff @(posedge clk_cpu) begin
        if (rd_pend) begin
            obj_entry <= rd_entry;
        end
    end

    // Entry handed to the engine is fully known whenever flagged valid
    entry_known: assert property (
        @(posedge clk_cpu) disable iff (rst) obj_valid |-> !$isunknown(obj_entry)
    );

endmodule

`default_nettype wire

// File: rtl/objram_pkg.sv
/* Object table shared types */
`default_nettype none

package objram_pkg;

    // Word position inside one object entry, from address bits 2:1
    typedef enum logic [1:0] {
        FIELD_X    = 2'd0,
        FIELD_Y    = 2'd1,
        FIELD_CODE = 2'd2,
        FIELD_ATTR = 2'd3
    } obj_field_e;

    // One full entry as seen by the object engine
    typedef struct packed {
        logic [15:0] x;
        logic [15:0] y;
        logic [15:0] code;
        logic [15:0] attr;
    } obj_entry_t;

    // CPU table write, word address bits 13:1
    typedef struct packed {
        logic        cs;
        logic [ 1:0] dsn;
        logic [13:1] addr;
        logic [15:0] data;
    } cpu_req_t;

    // Configuration register write
    typedef struct packed {
        logic        cs;
        logic [ 1:0] dsn;
        logic [ 3:1] addr;
        logic [15:0] data;
    } cfg_req_t;

    // Single RAM write, bank bit on top of the entry index
    typedef struct packed {
        obj_field_e  field;
        logic [10:0] bank_addr;
        logic [ 1:0] be;
        logic [15:0] data;
    } ram_wr_t;

    // Global position offsets
    typedef struct packed {
        logic [9:0] off_x;
        logic [8:0] off_y;
    } obj_offset_t;

    localparam logic [3:1] XOFF_REG = 3'd4;
    localparam logic [3:1] YOFF_REG = 3'd5;

    // Hardware bias removed from written offsets
    localparam logic [9:0] X_BIAS = 10'h040;
    localparam logic [8:0] Y_BIAS = 9'h010;

endpackage

`default_nettype wire

// File: rtl/objram_top.sv
/* Object table memory */
`timescale 1ns/1ns
`default_nettype none

module objram_top #(
    parameter int AW = 13
) (
    input  wire logic                   clk_cpu,
    input  wire logic                   rst,
    // CPU table writes
    input  wire objram_pkg::cpu_req_t   cpu_req,
    output logic                        ok,
    // Offset configuration
    input  wire objram_pkg::cfg_req_t   cfg_req,
    // Bank swap
    input  wire logic                   obank,
    // Object engine
    input  wire logic                   obj_rd,
    input  wire logic [AW-4:0]          obj_idx,
    output logic                        obj_valid,
    output objram_pkg::obj_entry_t      obj_entry
);

    objram_pkg::obj_offset_t offsets;
    objram_pkg::ram_wr_t     ram_wr;
    logic                    wr_en;
    logic [AW-4:0]           rd_addr;
    objram_pkg::obj_entry_t  rd_entry;

    objram_cfg_regs u_cfg_regs (
        .clk_cpu ( clk_cpu ),
        .rst     ( rst     ),
        .cfg_req ( cfg_req ),
        .offsets ( offsets )
    );

    objram_cpu_write #(.AW(AW)) u_cpu_write (
        .clk_cpu ( clk_cpu ),
        .rst     ( rst     ),
        .cpu_req ( cpu_req ),
        .obank   ( obank   ),
        .offsets ( offsets ),
        .ok      ( ok      ),
        .ram_wr  ( ram_wr  ),
        .wr_en   ( wr_en   )
    );

    objram_bank_store #(.AW(AW)) u_bank_store (
        .clk_cpu  ( clk_cpu  ),
        .ram_wr   ( ram_wr   ),
        .wr_en    ( wr_en    ),
        .obank    ( obank    ),
        .rd_addr  ( rd_addr  ),
        .rd_entry ( rd_entry )
    );

    objram_obj_read #(.AW(AW)) u_obj_read (
        .clk_cpu   ( clk_cpu   ),
        .rst       ( rst       ),
        .obj_rd    ( obj_rd    ),
        .obj_idx   ( obj_idx   ),
        .rd_addr   ( rd_addr   ),
        .rd_entry  ( rd_entry  ),
        .obj_valid ( obj_valid ),
        .obj_entry ( obj_entry )
    );

endmodule

`default_nettype wire

// File: include/objram_tb_tasks.svh
/* Object table testbench tasks */
`ifndef OBJRAM_TB_TASKS_SVH
`define OBJRAM_TB_TASKS_SVH

// Single compare point, mismatches counted for the report
task automatic check_value(input string name, input logic [15:0] expected,
                           input logic [15:0] actual);
    if (actual !== expected) begin
        $display("Fail %s expected %h actual %h", name, expected, actual);
        err_count++;
    end
endtask

// One CPU table write, select held for a single cycle
task automatic cpu_write(input logic [15:0] addr, input logic [1:0] dsn,
                         input logic [15:0] data);
    // Nothing left over from an earlier access
    check_value("ok", 16'h0, ok);
    cpu_req.cs   = 1'b1;
    cpu_req.dsn  = dsn;
    cpu_req.addr = addr[13:1];
    cpu_req.data = data;
    @(posedge clk_cpu);
    #1;
    cpu_req.cs = 1'b0;
    // Acknowledge exactly one cycle after select
    check_value("ok", 16'h1, ok);
    // RAM takes the write at this edge
    @(posedge clk_cpu);
    #1;
    check_value("ok", 16'h0, ok);
endtask

// Offset register write, active from the next edge
task automatic config_write(input logic [2:0] reg_num, input logic [1:0] dsn,
                            input logic [15:0] data);
    cfg_req.cs   = 1'b1;
    cfg_req.dsn  = dsn;
    cfg_req.addr = reg_num;
    cfg_req.data = data;
    @(posedge clk_cpu);
    #1;
    cfg_req.cs = 1'b0;
endtask

// Bank select change, one settling cycle
task automatic bank_set(input logic value);
    obank = value;
    @(posedge clk_cpu);
    #1;
endtask

// Queued reads issued on consecutive cycles
// Each valid checked exactly two cycles after its request
task automatic object_read_burst();
    int                     n;
    int                     k;
    int                     j;
    logic                   exp_valid;
    string                  tag;
    objram_pkg::obj_entry_t exp;
    n = rd_idx_q.size();
    for (k = 0; k < n + 2; k++) begin
        obj_rd  = (k < n);
        obj_idx = (k < n) ? rd_idx_q[k] : '0;
        @(posedge clk_cpu);
        #1;
        // Request j was issued two edges back
        j = k - 1;
        exp_valid = (j >= 0) && (j < n);
        check_value("obj_valid", {15'h0, exp_valid}, obj_valid);
        if (exp_valid) begin
            exp = rd_exp_q[j];
            tag = $sformatf("obj_entry[%0h]", rd_idx_q[j]);
            check_value({tag, ".x"}, exp.x, obj_entry.x);
            check_value({tag, ".y"}, exp.y, obj_entry.y);
            check_value({tag, ".code"}, exp.code, obj_entry.code);
            check_value({tag, ".attr"}, exp.attr, obj_entry.attr);
        end
    end
    rd_idx_q.delete();
    rd_exp_q.delete();
endtask

`endif

// File: testbench/objram_tb.sv
/* Object table testbench */
`timescale 1ns/1ns
`default_nettype none

module objram_tb;

    localparam int AW = 13;
    localparam DATA_FILE = "testbench/objram_testdata.txt";

    logic                   clk_cpu;
    logic                   rst;
    objram_pkg::cpu_req_t   cpu_req;
    logic                   ok;
    objram_pkg::cfg_req_t   cfg_req;
    logic                   obank;
    logic                   obj_rd;
    logic [AW-4:0]          obj_idx;
    logic                   obj_valid;
    objram_pkg::obj_entry_t obj_entry;

    // Reads waiting to go out as one back-to-back burst
    logic [AW-4:0]          rd_idx_q[$];
    objram_pkg::obj_entry_t rd_exp_q[$];

    int    err_count;
    int    test_errs_base;
    int    tests_passed;
    int    tests_failed;
    int    watchdog_cycles;
    string cur_name;

    objram_top #(.AW(AW)) uut (
        .clk_cpu   ( clk_cpu   ),
        .rst       ( rst       ),
        .cpu_req   ( cpu_req   ),
        .ok        ( ok        ),
        .cfg_req   ( cfg_req   ),
        .obank     ( obank     ),
        .obj_rd    ( obj_rd    ),
        .obj_idx   ( obj_idx   ),
        .obj_valid ( obj_valid ),
        .obj_entry ( obj_entry )
    );

    `include "objram_tb_tasks.svh"

    initial clk_cpu = 1'b0;
    always #5 clk_cpu = ~clk_cpu;

    // Rest of a comment line
    task automatic skip_line(input int fd);
        int c;
        c = 0;
        while (c != 10 && c != -1) begin
            c = $fgetc(fd);
        end
    endtask

    // Line count sizes the watchdog
    task automatic count_lines(output int lines);
        int fd;
        int c;
        lines = 0;
        fd = $fopen(DATA_FILE, "r");
        if (fd != 0) begin
            c = $fgetc(fd);
            while (c != -1) begin
                if (c == 10) begin
                    lines++;
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
        end
    endtask

    task automatic record_error(input int fd, input logic [7:0] op);
        $display("Bad or unknown record with op '%c' in test %s", op, cur_name);
        err_count++;
        skip_line(fd);
    endtask

    // Per-test summary line
    task automatic close_test();
        int errs;
        errs = err_count - test_errs_base;
        if (errs == 0) begin
            tests_passed++;
            $display("test %s passed", cur_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d mismatches", cur_name, errs);
        end
        test_errs_base = err_count;
    endtask

    // Record sequencer, one operation per line
    task automatic run_records(input int fd);
        int              code;
        logic [7:0]      op;
        logic [15:0]     f_a;
        logic [15:0]     f_b;
        logic [15:0]     f_c;
        logic [15:0]     f_d;
        logic [15:0]     f_e;
        logic [8*32-1:0] name_bits;
        bit              done;
        objram_pkg::obj_entry_t exp;
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %c", op);
            if (code != 1) begin
                done = 1'b1;
            end else if (op == "#") begin
                skip_line(fd);
            end else begin
                // Any other record closes a pending read burst
                if (op != "R" && rd_idx_q.size() > 0) begin
                    object_read_burst();
                end
                case (op)
                    "C": begin
                        code = $fscanf(fd, "%h %h %h", f_a, f_b, f_c);
                        if (code == 3) config_write(f_a[2:0], f_b[1:0], f_c);
                        else record_error(fd, op);
                    end
                    "B": begin
                        code = $fscanf(fd, "%h", f_a);
                        if (code == 1) bank_set(f_a[0]);
                        else record_error(fd, op);
                    end
                    "W": begin
                        code = $fscanf(fd, "%h %h %h", f_a, f_b, f_c);
                        if (code == 3) cpu_write(f_a, f_b[1:0], f_c);
                        else record_error(fd, op);
                    end
                    "R": begin
                        code = $fscanf(fd, "%h %h %h %h %h", f_a, f_b, f_c, f_d, f_e);
                        if (code == 5) begin
                            exp.x    = f_b;
                            exp.y    = f_c;
                            exp.code = f_d;
                            exp.attr = f_e;
                            rd_idx_q.push_back(f_a[AW-4:0]);
                            rd_exp_q.push_back(exp);
                        end else begin
                            record_error(fd, op);
                        end
                    end
                    "T": begin
                        code = $fscanf(fd, " %s", name_bits);
                        close_test();
                        cur_name = $sformatf("%0s", name_bits);
                    end
                    default: record_error(fd, op);
                endcase
            end
        end
        if (rd_idx_q.size() > 0) begin
            object_read_burst();
        end
    endtask

    // Watchdog, generous per-line budget
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk_cpu);
        $display("Run timed out after %0d cycles", watchdog_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int fd;
        int lines;
        rst            = 1'b1;
        cpu_req        = '0;
        cfg_req        = '0;
        obank          = 1'b0;
        obj_rd         = 1'b0;
        obj_idx        = '0;
        err_count      = 0;
        test_errs_base = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        cur_name       = "reset";
        count_lines(lines);
        watchdog_cycles = (lines + 10) * 20;
        repeat (4) @(posedge clk_cpu);
        #1;
        rst = 1'b0;
        // Both handshake outputs idle out of reset
        check_value("ok", 16'h0, ok);
        check_value("obj_valid", 16'h0, obj_valid);
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("Could not open %0s", DATA_FILE);
            err_count++;
        end else begin
            run_records(fd);
            $fclose(fd);
        end
        close_test();
        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/objram_testdata.txt
# C reg dsn data | B obank | W byte_addr dsn data | T test_name
# R index exp_x exp_y exp_code exp_attr, all values hex
T basic_write
W 2028 0 1234
W 202a 0 abcd
W 202c 0 5a5a
W 202e 0 c3f0
W 3ff8 0 0001
W 3ffa 0 ffff
W 3ffc 0 8000
W 3ffe 0 7fff
R 005 1234 abcd 5a5a c3f0
R 3ff 0001 ffff 8000 7fff
T byte_lanes
W 202c 2 11ee
W 202e 1 9922
W 2028 2 ff77
W 202a 3 0000
R 005 1277 abcd 5aee 99f0
T offsets
C 4 0 0145
C 5 0 0123
W 2080 0 fc00
W 2082 0 8350
W 2084 0 0042
W 2086 0 0007
R 010 fefb 823d 0042 0007
C 4 2 aa80
C 5 1 0000
W 2088 0 0123
W 208a 0 0001
W 208c 0 1111
W 208e 0 2222
R 011 03e3 01fe 1111 2222
# Offsets back to zero
C 4 0 0040
C 5 0 0010
T bank_swap
W 2100 0 0aaa
W 2102 0 0bbb
W 2104 0 0ccc
W 2106 0 0ddd
W 0100 0 0111
W 0102 0 0222
W 0104 0 0333
W 0106 0 0444
R 020 0aaa 0bbb 0ccc 0ddd
B 1
R 020 0111 0222 0333 0444
W 0104 0 beef
R 020 0111 0222 0333 0444
B 0
R 020 0aaa 0bbb beef 0ddd
T back_to_back
R 005 1277 abcd 5aee 99f0
R 3ff 0001 ffff 8000 7fff
R 010 fefb 823d 0042 0007
R 011 03e3 01fe 1111 2222
R 020 0aaa 0bbb beef 0ddd
R 005 1277 abcd 5aee 99f0
